// File: hdl/dmm_pkg.sv
/*
  dmm front end control core
  shared widths, register map, frame layout and output bundle positions
*/
package dmm_pkg;

  // widths
  localparam int unsigned DATA_W     = 24;  // registers and output bundle
  localparam int unsigned ADDR_W     = 7;   // command bit 7 is the read flag
  localparam int unsigned CMD_BITS   = 8;
  localparam int unsigned FRAME_BITS = 32;  // command byte + 24 data bits
  localparam int unsigned BITCNT_W   = 6;   // saturating frame bit count
  localparam int unsigned HW_FLAGS_W = 3;

  // register map
  localparam logic [ADDR_W-1:0] REG_STATUS    = 7'd0;  // read only
  localparam logic [ADDR_W-1:0] REG_MODE      = 7'd1;
  localparam logic [ADDR_W-1:0] REG_DIRECT    = 7'd2;
  localparam logic [ADDR_W-1:0] REG_APERTURE  = 7'd3;  // sample length, clk cycles
  localparam logic [ADDR_W-1:0] REG_PRECHARGE = 7'd4;  // precharge length, clk cycles

  localparam logic [7:0]        STATUS_MAGIC    = 8'hAA;
  localparam logic [DATA_W-1:0] LED_HOLD_CYCLES = 24'd64;  // activity light on-time

  //////////////////////////////////////////////////////////////////////
  // output bundle layout
  localparam int unsigned LED_LSB           = 0;
  localparam int unsigned LED_W             = 4;
  localparam int unsigned MON_LSB           = 4;
  localparam int unsigned MON_W             = 8;
  localparam int unsigned BIT_MEAS_COMPLETE = 12;
  localparam int unsigned BIT_PC1           = 13;
  localparam int unsigned BIT_PC2           = 14;
  localparam int unsigned AZMUX_LSB         = 15;
  localparam int unsigned BIT_CMPR_LATCH    = 19;
  localparam int unsigned REFMUX_LSB        = 20;
  localparam int unsigned SEL_W             = 4;   // azmux and refmux

  // output source, 5..7 fall through to all low
  typedef enum logic [2:0] {
    MODE_DIRECT    = 3'd0,
    MODE_ALL_LOW   = 3'd1,
    MODE_ALL_HIGH  = 3'd2,
    MODE_PATTERN   = 3'd3,
    MODE_PRECHARGE = 3'd4
  } out_mode_t;

  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_PRECHARGE = 2'd1,
    ST_SAMPLE    = 2'd2
  } seq_state_t;

endpackage

// File: hdl/interval_timer.sv
/*
  loadable interval timer
  done pulses N cycles after a load of N, zero counts as one
*/
`timescale 1ns/1ps

module interval_timer (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       load_i,
  input  logic [dmm_pkg::DATA_W-1:0] interval_i,
  output logic                       busy_o,
  output logic                       done_o
);

  import dmm_pkg::*;

  logic [DATA_W-1:0] count_r;  // cycles left, 0 when idle

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (load_i) begin  // reload wins over decrement
      count_r <= (interval_i == '0) ? DATA_W'(1) : interval_i;
    end else if (count_r != '0) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign busy_o = (count_r != '0);
  assign done_o = (count_r == DATA_W'(1));  // last counted cycle

  //////////////////////////////////////////////////////////////////////
  // checks

  // only a fresh load can bring done back on the next cycle
  a_done_single : assert property (
    @(posedge clk_i) disable iff (reset_i)
    done_o && !load_i |=> !done_o
  );

endmodule

// File: hdl/spi_reg_bank.sv
/*
  spi slave and register file, mode 0, oversampled on clk
  32 bit frames, command byte then 24 data bits, msb first
  writes commit on ss_n rising edge, reads shift out after the command
*/
`timescale 1ns/1ps

module spi_reg_bank (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           sck_i,
  input  logic                           sdi_i,
  input  logic                           ss_n_i,
  output logic                           sdo_o,
  input  logic [dmm_pkg::HW_FLAGS_W-1:0] hw_flags_i,
  output dmm_pkg::out_mode_t             mode_o,
  output logic [dmm_pkg::DATA_W-1:0]     direct_o,
  output logic [dmm_pkg::DATA_W-1:0]     aperture_o,
  output logic [dmm_pkg::DATA_W-1:0]     precharge_o,
  output logic                           frame_done_o
);

  import dmm_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // pin synchronizers and edge detect
  logic [2:0] sck_r;  // [1] synced, [2] previous
  logic [2:0] ss_r;
  logic [1:0] sdi_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sck_r <= '0;   // mode 0 idles low
      ss_r  <= '1;   // deselected
      sdi_r <= '0;
    end else begin
      sck_r <= {sck_r[1:0], sck_i};
      ss_r  <= {ss_r[1:0], ss_n_i};
      sdi_r <= {sdi_r[0], sdi_i};
    end
  end

  logic sck_rise, sck_fall, ss_fall, ss_rise, frame_act;

  assign sck_rise  = sck_r[1] & ~sck_r[2];
  assign sck_fall  = ~sck_r[1] & sck_r[2];
  assign ss_fall   = ~ss_r[1] & ss_r[2];   // frame opens
  assign ss_rise   = ss_r[1] & ~ss_r[2];   // frame closes
  assign frame_act = ~ss_r[1];

  //////////////////////////////////////////////////////////////////////
  // receive side
  logic [BITCNT_W-1:0]   bit_cnt_r;
  logic [FRAME_BITS-1:0] shift_r;   // cmd in [31:24] once full
  logic                  cmd_done_r; // command byte just completed

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bit_cnt_r  <= '0;
      cmd_done_r <= 1'b0;
    end else begin
      cmd_done_r <= frame_act && sck_rise && (bit_cnt_r == BITCNT_W'(CMD_BITS - 1));
      if (ss_fall)
        bit_cnt_r <= '0;
      else if (frame_act && sck_rise && (bit_cnt_r != '1))
        bit_cnt_r <= bit_cnt_r + 1'b1;  // saturate, long frames stay invalid
    end
  end

  always_ff @(posedge clk_i) begin
    if (frame_act && sck_rise)
      shift_r <= {shift_r[FRAME_BITS-2:0], sdi_r[1]};
  end

  //////////////////////////////////////////////////////////////////////
  // register file
  out_mode_t         mode_r;
  logic [DATA_W-1:0] direct_r, aperture_r, precharge_r;
  logic              wr_ok;
  logic [ADDR_W-1:0] wr_addr;

  assign wr_ok   = ss_rise && (bit_cnt_r == BITCNT_W'(FRAME_BITS))
                   && !shift_r[FRAME_BITS-1];
  assign wr_addr = shift_r[FRAME_BITS-2 -: ADDR_W];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_r      <= MODE_DIRECT;
      direct_r    <= '0;
      aperture_r  <= '0;
      precharge_r <= '0;
    end else if (wr_ok) begin
      case (wr_addr)
        REG_MODE:      mode_r      <= out_mode_t'(shift_r[2:0]);
        REG_DIRECT:    direct_r    <= shift_r[DATA_W-1:0];
        REG_APERTURE:  aperture_r  <= shift_r[DATA_W-1:0];
        REG_PRECHARGE: precharge_r <= shift_r[DATA_W-1:0];
        default: ;  // status and unknown addresses drop the write
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback, sdo changes on sck falling
  logic [DATA_W-1:0] rd_data, tx_r;
  logic              sdo_r;

  always_comb begin
    rd_data = '0;  // unknown address reads zero
    case (shift_r[ADDR_W-1:0])  // command byte sits in the low bits here
      REG_STATUS:    rd_data = {{(DATA_W-HW_FLAGS_W-8){1'b0}}, hw_flags_i, STATUS_MAGIC};
      REG_MODE:      rd_data = {{(DATA_W-3){1'b0}}, mode_r};
      REG_DIRECT:    rd_data = direct_r;
      REG_APERTURE:  rd_data = aperture_r;
      REG_PRECHARGE: rd_data = precharge_r;
      default:       rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (ss_fall)
      tx_r <= '0;
    else if (cmd_done_r)
      tx_r <= shift_r[CMD_BITS-1] ? rd_data : '0;  // load only for a read
    else if (frame_act && sck_fall)
      tx_r <= {tx_r[DATA_W-2:0], 1'b0};
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || !frame_act)
      sdo_r <= 1'b0;  // quiet between frames
    else if (sck_fall)
      sdo_r <= tx_r[DATA_W-1];
  end

  assign sdo_o        = sdo_r;
  assign mode_o       = mode_r;
  assign direct_o     = direct_r;
  assign aperture_o   = aperture_r;
  assign precharge_o  = precharge_r;
  assign frame_done_o = ss_rise;  // every close, valid or not

  // host holds each sck level at least 3 clk, so no fall follows a rise early
  a_sck_edges : assert property (
    @(posedge clk_i) disable iff (reset_i)
    sck_rise |-> (!sck_fall) [*3]
  );

endmodule

// File: hdl/precharge_seq.sv
/*
  precharge / sample sequencer
  alternates phases, lengths taken from registers at each phase load
*/
`timescale 1ns/1ps

module precharge_seq (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [dmm_pkg::DATA_W-1:0] aperture_i,
  input  logic [dmm_pkg::DATA_W-1:0] precharge_i,
  output logic                       pc_sw_o,
  output logic                       seq_led_o,
  output logic [dmm_pkg::MON_W-1:0]  seq_mon_o,
  output logic                       meas_done_o
);

  import dmm_pkg::*;

  seq_state_t        state_r, state_d;
  logic              tmr_load;
  logic [DATA_W-1:0] tmr_len;
  logic              tmr_busy, tmr_done;

  // phase length timer
  interval_timer phase_tmr_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .load_i     (tmr_load),
    .interval_i (tmr_len),
    .busy_o     (tmr_busy),
    .done_o     (tmr_done)
  );

  //////////////////////////////////////////////////////////////////////
  // fsm, timer loaded on the cycle before each phase starts
  always_comb begin
    state_d  = state_r;
    tmr_load = 1'b0;
    tmr_len  = precharge_i;
    case (state_r)
      ST_IDLE: begin  // one cycle out of reset
        tmr_load = 1'b1;
        state_d  = ST_PRECHARGE;
      end
      ST_PRECHARGE: if (tmr_done) begin
        tmr_load = 1'b1;
        tmr_len  = aperture_i;
        state_d  = ST_SAMPLE;
      end
      ST_SAMPLE: if (tmr_done) begin
        tmr_load = 1'b1;  // back to precharge, fresh length
        state_d  = ST_PRECHARGE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      state_r <= ST_IDLE;
    else
      state_r <= state_d;
  end

  // outputs, decoded from state
  assign pc_sw_o     = (state_r == ST_SAMPLE);
  assign seq_led_o   = (state_r == ST_SAMPLE);
  assign seq_mon_o   = {{(MON_W-2){1'b0}}, state_r == ST_PRECHARGE, state_r == ST_SAMPLE};
  assign meas_done_o = (state_r == ST_SAMPLE) && tmr_done;  // last sample cycle

  //////////////////////////////////////////////////////////////////////
  // checks

  // timer always running while a phase is active
  a_phase_timed : assert property (
    @(posedge clk_i) disable iff (reset_i)
    state_r != ST_IDLE |-> tmr_busy
  );

endmodule

// File: hdl/output_mux.sv
/*
  output source selector
  registered mux over direct, fixed levels, test pattern and sequencer
  also owns the pattern counter and the spi activity light hold
*/
`timescale 1ns/1ps

module output_mux (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  dmm_pkg::out_mode_t         mode_i,
  input  logic [dmm_pkg::DATA_W-1:0] direct_i,
  input  logic                       frame_done_i,
  input  logic                       pc_sw_i,
  input  logic                       seq_led_i,
  input  logic [dmm_pkg::MON_W-1:0]  seq_mon_i,
  input  logic                       meas_done_i,
  output logic [dmm_pkg::DATA_W-1:0] out_o
);

  import dmm_pkg::*;

  logic              act_led;    // spi activity, held after each frame
  logic [DATA_W-1:0] pattern_r;  // free running test pattern
  logic [DATA_W-1:0] bundle_d;
  logic [DATA_W-1:0] out_r;

  // retriggers on every frame close
  interval_timer led_hold_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .load_i     (frame_done_i),
    .interval_i (LED_HOLD_CYCLES),
    .busy_o     (act_led),
    .done_o     ()
  );

  always_ff @(posedge clk_i) begin
    if (reset_i)
      pattern_r <= '0;
    else
      pattern_r <= pattern_r + 1'b1;  // wraps at 2^24
  end

  //////////////////////////////////////////////////////////////////////
  // source select
  always_comb begin
    bundle_d = '0;
    case (mode_i)
      MODE_DIRECT: begin
        bundle_d          = direct_i;
        bundle_d[LED_LSB] = act_led;  // led 0 shows spi activity
      end
      MODE_ALL_LOW:  bundle_d = '0;
      MODE_ALL_HIGH: bundle_d = '1;
      MODE_PATTERN:  bundle_d = pattern_r;
      MODE_PRECHARGE: begin  // sequencer bits only, rest low
        bundle_d[LED_LSB]             = seq_led_i;
        bundle_d[MON_LSB +: MON_W]    = seq_mon_i;
        bundle_d[BIT_MEAS_COMPLETE]   = meas_done_i;
        bundle_d[BIT_PC1]             = pc_sw_i;
      end
      default: bundle_d = '0;  // 5..7 unused
    endcase
  end

  // one cycle behind the sources
  always_ff @(posedge clk_i) begin
    if (reset_i)
      out_r <= '0;  // pins low out of reset
    else
      out_r <= bundle_d;
  end

  assign out_o = out_r;

endmodule

// File: hdl/dmm_ctrl_top.sv
/*
  dmm front end control core, top level
  spi register bank, precharge sequencer and output mux to the pins
*/
`timescale 1ns/1ps

module dmm_ctrl_top (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // spi, mode 0
  input  logic                           sck_i,
  input  logic                           sdi_i,
  input  logic                           ss_n_i,
  output logic                           sdo_o,
  input  logic [dmm_pkg::HW_FLAGS_W-1:0] hw_flags_i,
  // switch and indicator outputs
  output logic [dmm_pkg::LED_W-1:0]      leds_o,
  output logic [dmm_pkg::MON_W-1:0]      monitor_o,
  output logic                           meas_complete_o,
  output logic                           pc1_sw_o,
  output logic                           pc2_sw_o,
  output logic [dmm_pkg::SEL_W-1:0]      azmux_o,
  output logic                           cmpr_latch_o,
  output logic [dmm_pkg::SEL_W-1:0]      refmux_o
);

  import dmm_pkg::*;

  out_mode_t         mode;
  logic [DATA_W-1:0] direct, aperture, precharge;
  logic              frame_done;
  logic              pc_sw, seq_led, meas_done;
  logic [MON_W-1:0]  seq_mon;
  logic [DATA_W-1:0] bundle;  // registered output word

  spi_reg_bank spi_reg_bank_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .sck_i        (sck_i),
    .sdi_i        (sdi_i),
    .ss_n_i       (ss_n_i),
    .sdo_o        (sdo_o),
    .hw_flags_i   (hw_flags_i),
    .mode_o       (mode),
    .direct_o     (direct),
    .aperture_o   (aperture),
    .precharge_o  (precharge),
    .frame_done_o (frame_done)
  );

  precharge_seq precharge_seq_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .aperture_i  (aperture),
    .precharge_i (precharge),
    .pc_sw_o     (pc_sw),
    .seq_led_o   (seq_led),
    .seq_mon_o   (seq_mon),
    .meas_done_o (meas_done)
  );

  output_mux output_mux_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mode_i       (mode),
    .direct_i     (direct),
    .frame_done_i (frame_done),
    .pc_sw_i      (pc_sw),
    .seq_led_i    (seq_led),
    .seq_mon_i    (seq_mon),
    .meas_done_i  (meas_done),
    .out_o        (bundle)
  );

  //////////////////////////////////////////////////////////////////////
  // bundle to pins
  assign leds_o          = bundle[LED_LSB +: LED_W];
  assign monitor_o       = bundle[MON_LSB +: MON_W];
  assign meas_complete_o = bundle[BIT_MEAS_COMPLETE];
  assign pc1_sw_o        = bundle[BIT_PC1];
  assign pc2_sw_o        = bundle[BIT_PC2];
  assign azmux_o         = bundle[AZMUX_LSB +: SEL_W];
  assign cmpr_latch_o    = bundle[BIT_CMPR_LATCH];
  assign refmux_o        = bundle[REFMUX_LSB +: SEL_W];  // adc ref current mux

endmodule

// File: include/tb_spi_tasks.svh
/*
  testbench helpers for the dmm control core
  spi mode 0 frames, random source and typed compares
*/
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// xorshift32, nonzero seed never reaches zero
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

task automatic wait_clks(input int n);
  repeat (n) @(posedge clk);
endtask

//////////////////////////////////////////////////////////////////////
// spi host, each sck level held 4 clk
task automatic spi_frame(input logic [7:0] cmd, input logic [DATA_W-1:0] wdata,
                         input int nbits, output logic [DATA_W-1:0] rdata);
  logic [FRAME_BITS-1:0] word;
  int i;
  word  = {cmd, wdata};
  rdata = '0;
  @(posedge clk);
  ss_n <= 1'b0;  // open frame
  sck  <= 1'b0;
  wait_clks(4);
  for (i = 0; i < nbits; i++) begin
    sdi <= word[FRAME_BITS-1-i];  // msb first, set while sck low
    wait_clks(4);
    if (i >= CMD_BITS)
      rdata = {rdata[DATA_W-2:0], sdo};  // sampled just before the rise
    sck <= 1'b1;
    wait_clks(4);
    sck <= 1'b0;
  end
  wait_clks(4);
  ss_n <= 1'b1;  // close, write commits here
  sdi  <= 1'b0;
  wait_clks(4);
endtask

task automatic spi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
  logic [DATA_W-1:0] ignored;
  spi_frame({1'b0, addr}, data, FRAME_BITS, ignored);
endtask

task automatic spi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
  spi_frame({1'b1, addr}, '0, FRAME_BITS, data);  // read flag in bit 7
endtask

//////////////////////////////////////////////////////////////////////
// compares
task automatic check_bundle(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
  if (got !== exp)
    stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s, bundle %h expected %h",
                                $time, what, got, exp));
endtask

task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input string what);
  if (got !== exp)
    stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s, word %h expected %h",
                                $time, what, got, exp));
endtask

task automatic check_mode(input out_mode_t got, input out_mode_t exp, input string what);
  if (got !== exp)
    stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s, mode %0d expected %0d",
                                $time, what, got, exp));
endtask

`endif

// File: tests/tb_dmm_ctrl.sv
/*
  testbench for the dmm front end control core
  register access over spi, output modes, test pattern and sequencer phase widths
*/
`timescale 1ns/1ps

module tb_dmm_ctrl;

  import dmm_pkg::*;

  typedef enum logic [1:0] {
    OP_WRITE,  // write, then check bundle
    OP_READ,   // read, check register word
    OP_SHORT,  // truncated write, bundle must not move
    OP_HOLD    // let the activity led run out
  } op_t;

  typedef struct packed {
    op_t               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] expected;  // bundle, or register word for reads
  } step_t;

  localparam logic [HW_FLAGS_W-1:0] HW_FLAGS    = 3'b101;
  localparam int                    SHORT_BITS  = 31;  // one bit short of a frame
  localparam int                    NUM_SEQ     = 5;
  localparam int                    PHASE_LIMIT = 200;
  // phase lengths, entry 0 in the low byte
  localparam logic [NUM_SEQ*8-1:0]  APER_LIST   = {8'd0, 8'd7, 8'd1, 8'd0, 8'd3};
  localparam logic [NUM_SEQ*8-1:0]  PRECH_LIST  = {8'd4, 8'd0, 8'd2, 8'd0, 8'd5};

  logic clk, reset, sck, sdi, ss_n, sdo;
  logic [HW_FLAGS_W-1:0] hw_flags;
  logic [LED_W-1:0]      leds;
  logic [MON_W-1:0]      monitor;
  logic                  meas_complete, pc1_sw, pc2_sw, cmpr_latch;
  logic [SEL_W-1:0]      azmux, refmux;
  logic [DATA_W-1:0]     pins;  // pins packed back into bundle order
  logic [31:0]           rng_state;
  step_t                 steps[$];

  assign pins = {refmux, cmpr_latch, azmux, pc2_sw, pc1_sw, meas_complete, monitor, leds};

  dmm_ctrl_top dmm_ctrl_top_i (
    .clk_i           (clk),
    .reset_i         (reset),
    .sck_i           (sck),
    .sdi_i           (sdi),
    .ss_n_i          (ss_n),
    .sdo_o           (sdo),
    .hw_flags_i      (hw_flags),
    .leds_o          (leds),
    .monitor_o       (monitor),
    .meas_complete_o (meas_complete),
    .pc1_sw_o        (pc1_sw),
    .pc2_sw_o        (pc2_sw),
    .azmux_o         (azmux),
    .cmpr_latch_o    (cmpr_latch),
    .refmux_o        (refmux)
  );

  always #10 clk = ~clk;  // 50 MHz

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "tb_spi_tasks.svh"

  task automatic add_step(input op_t op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] expected);
    step_t s;
    s.op       = op;
    s.addr     = addr;
    s.data     = data;
    s.expected = expected;
    steps.push_back(s);
  endtask

  function automatic logic [DATA_W-1:0] seq_bundle(input logic in_sample);
    logic [DATA_W-1:0] b;
    b                  = '0;
    b[LED_LSB]         = in_sample;
    b[MON_LSB]         = in_sample;   // monitor bit 0, sample
    b[MON_LSB + 1]     = !in_sample;  // monitor bit 1, precharge
    b[BIT_PC1]         = in_sample;
    return b;
  endfunction

  task automatic wait_pc1(input logic level);
    int cnt;
    cnt = 0;
    while (pins[BIT_PC1] !== level) begin
      if (cnt >= PHASE_LIMIT)
        stop_with_failure($sformatf("timeout: pc1 never went to %0b", level));
      cnt++;
      @(posedge clk);
    end
  endtask

  // counts cycles at one pc1 level, notes meas_complete pulses
  task automatic measure_phase(input logic level, output int width, output int done_cnt,
                               output int done_pos);
    width    = 0;
    done_cnt = 0;
    done_pos = -1;
    while (pins[BIT_PC1] === level) begin
      if (width >= PHASE_LIMIT)
        stop_with_failure($sformatf("timeout: pc1 stuck at %0b", level));
      check_bundle(pins & ~(DATA_W'(1) << BIT_MEAS_COMPLETE), seq_bundle(level),
                   "sequencer bits");
      if (pins[BIT_MEAS_COMPLETE]) begin
        done_cnt++;
        done_pos = width;
      end
      width++;
      @(posedge clk);
    end
  endtask

  initial begin
    step_t             st;
    logic [DATA_W-1:0] rd, d, e, prev, status_word;
    int                n, m, exp_a, exp_p, width, done_cnt, done_pos;

    clk       = 1'b0;
    reset     = 1'b1;
    sck       = 1'b0;
    sdi       = 1'b0;
    ss_n      = 1'b1;
    hw_flags  = HW_FLAGS;
    rng_state = 32'ha411e1a9;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    wait_clks(8);
    check_bundle(pins, '0, "pins after reset");
    check_word({{(DATA_W-1){1'b0}}, sdo}, '0, "sdo after reset");

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    status_word = {{(DATA_W-HW_FLAGS_W-8){1'b0}}, HW_FLAGS, STATUS_MAGIC};
    add_step(OP_READ, REG_STATUS, '0, status_word);
    for (n = 0; n < 4; n++) begin
      rng_state = xorshift32(rng_state);
      d         = rng_state[DATA_W-1:0];
      e         = d;
      e[LED_LSB] = 1'b1;  // activity light right after the frame
      add_step(OP_WRITE, REG_DIRECT, d, e);
      add_step(OP_READ, REG_DIRECT, '0, d);
      e[LED_LSB] = 1'b0;  // light gone, led 0 stays low
      add_step(OP_HOLD, REG_DIRECT, '0, e);
    end
    add_step(OP_WRITE, REG_MODE, DATA_W'(MODE_ALL_HIGH), '1);
    add_step(OP_READ, REG_MODE, '0, DATA_W'(MODE_ALL_HIGH));
    // shifted by the missing bit this would land in the mode register as all low
    add_step(OP_SHORT, REG_DIRECT, 24'h000002, '1);
    add_step(OP_WRITE, REG_MODE, DATA_W'(MODE_ALL_LOW), '0);
    for (m = 5; m < 8; m++) begin  // unused modes drive low
      add_step(OP_WRITE, REG_MODE, DATA_W'(MODE_ALL_HIGH), '1);
      add_step(OP_WRITE, REG_MODE, DATA_W'(m), '0);
    end
    add_step(OP_READ, REG_MODE, '0, DATA_W'(7));
    add_step(OP_WRITE, REG_STATUS, DATA_W'(MODE_ALL_HIGH), '0);  // read only, dropped
    add_step(OP_READ, REG_STATUS, '0, status_word);

    foreach (steps[i]) begin
      st = steps[i];
      case (st.op)
        OP_WRITE: begin
          spi_write(st.addr, st.data);
          wait_clks(8);
          check_bundle(pins, st.expected, $sformatf("step %0d write", i));
        end
        OP_SHORT: begin
          spi_frame({1'b0, st.addr}, st.data, SHORT_BITS, rd);
          wait_clks(8);
          check_bundle(pins, st.expected, $sformatf("step %0d short frame", i));
        end
        OP_HOLD: begin
          wait_clks(int'(LED_HOLD_CYCLES) + 8);
          check_bundle(pins, st.expected, $sformatf("step %0d led hold", i));
        end
        default: begin
          spi_read(st.addr, rd);
          if (st.addr == REG_MODE)
            check_mode(out_mode_t'(rd[2:0]), out_mode_t'(st.expected[2:0]), "mode readback");
          check_word(rd, st.expected, $sformatf("step %0d read", i));
        end
      endcase
    end

    //////////////////////////////////////////////////////////////////////
    // pattern counter, +1 every cycle
    spi_write(REG_MODE, DATA_W'(MODE_PATTERN));
    wait_clks(8);
    prev = pins;
    for (n = 0; n < 16; n++) begin
      @(posedge clk);
      check_bundle(pins, prev + 1'b1, "test pattern step");
      prev = pins;
    end

    //////////////////////////////////////////////////////////////////////
    // sequencer phase widths
    spi_write(REG_MODE, DATA_W'(MODE_PRECHARGE));
    for (n = 0; n < NUM_SEQ; n++) begin
      spi_write(REG_APERTURE, DATA_W'(APER_LIST[n*8 +: 8]));
      spi_write(REG_PRECHARGE, DATA_W'(PRECH_LIST[n*8 +: 8]));
      exp_a = (APER_LIST[n*8 +: 8] == 0) ? 1 : int'(APER_LIST[n*8 +: 8]);
      exp_p = (PRECH_LIST[n*8 +: 8] == 0) ? 1 : int'(PRECH_LIST[n*8 +: 8]);
      wait_clks(8);
      wait_pc1(1'b0);  // skip any phase loaded before the write
      wait_pc1(1'b1);
      measure_phase(1'b1, width, done_cnt, done_pos);
      check_word(DATA_W'(width), DATA_W'(exp_a), "pc1 high width");
      check_word(DATA_W'(done_cnt), DATA_W'(1), "meas_complete pulses in sample");
      check_word(DATA_W'(done_pos), DATA_W'(exp_a - 1), "meas_complete position");
      measure_phase(1'b0, width, done_cnt, done_pos);
      check_word(DATA_W'(width), DATA_W'(exp_p), "pc1 low width");
      check_word(DATA_W'(done_cnt), '0, "meas_complete in precharge");
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: list.f
+incdir+include
hdl/dmm_pkg.sv
hdl/interval_timer.sv
hdl/spi_reg_bank.sv
hdl/precharge_seq.sv
hdl/output_mux.sv
hdl/dmm_ctrl_top.sv
tests/tb_dmm_ctrl.sv
